// File: list.f
design/dial_pkg.sv
design/quad_pkg.sv
design/dial_rate.sv
design/quad_gen.sv
design/quad_counter.sv
design/dial_emu.sv
design/dial_top.sv
tb/tb_dial.sv

// File: Makefile
TOP = tb_dial

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

// File: tb/tb_dial.sv
// Testbench for dial_top with LEFT_BIT 0 and 8-bit counts; the model wraps counts like the DUT.
`timescale 1ns/1ps

module tb_dial;
    import dial_pkg::*;
    import quad_pkg::*;

    localparam int CW = 8;
    localparam logic [1:0] ACT_SPIN  = 2'd0;
    localparam logic [1:0] ACT_LINES = 2'd1;
    localparam logic [1:0] ACT_CLEAR = 2'd2;
    localparam logic [2:0] D_NONE = 3'd0;
    localparam logic [2:0] D_INC  = 3'd1;
    localparam logic [2:0] D_DEC  = 3'd2;
    localparam logic [2:0] D_BOTH = 3'd3;
    localparam logic [2:0] D_RAND = 3'd4; // Picked once as the table is built.
    localparam int SETTLE = 200; // Longest burst is 66 steps at half rate.

    typedef struct packed {
        dial_cfg_t            cfg;
        logic [1:0]           act;
        logic                 who;    // 0 is player 1, 1 is player 2.
        logic [2:0]           dir;
        logic [7:0]           n;
        logic signed [CW-1:0] exp_x;  // Counts after the entry.
        logic signed [CW-1:0] exp_y;
        logic [1:0]           rank_x; // Gray places after the entry.
        logic [1:0]           rank_y;
    } entry_t;

    logic                 clk, rst, lhbl, clear;
    player_in_t           p1, p2;
    dial_cfg_t            cfg;
    quad_t                dial_x, dial_y;
    logic signed [CW-1:0] count_x, count_y;

    entry_t               tbl[$];
    entry_t               model;    // Running model state while the table is built.
    int                   line_cnt; // Lines since reset.

    dial_top #(.LEFT_BIT(0), .COUNT_WIDTH(CW)) dut0 (
        .clk(clk), .rst(rst), .lhbl(lhbl), .player1(p1), .player2(p2),
        .cfg(cfg), .clear(clear), .dial_x(dial_x), .dial_y(dial_y),
        .count_x(count_x), .count_y(count_y)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_stop(string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_count(string what, logic signed [CW-1:0] got, logic signed [CW-1:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_phase(string what, quad_t got, quad_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // Gray order 00, 01, 11, 10.
    function automatic quad_t gray_of(logic [1:0] r);
        case (r)
            2'd1: return 2'b01;
            2'd2: return 2'b11;
            2'd3: return 2'b10;
            default: return 2'b00;
        endcase
    endfunction

    function automatic int joy_thr(logic [1:0] s);
        case (s)
            2'd1: return 7;
            2'd0: return 5;
            2'd3: return 3;
            default: return 1;
        endcase
    endfunction

    // Steps in one emulated spinner burst.
    function automatic int burst_steps(logic [1:0] s);
        return (2 ** s) * 8 + 2;
    endfunction

    // Sign of one step after reverse, 0 when the direction cancels.
    function automatic int dir_sign(logic [2:0] d, logic rev);
        int s;
        s = (d == D_INC) ? 1 : (d == D_DEC) ? -1 : 0;
        return rev ? -s : s;
    endfunction

    task automatic tick(int n);
        repeat (n) @(posedge clk);
        #2; // Drive just after the edge.
    endtask

    task automatic drive_player(logic who, player_in_t pl);
        if (who) begin
            p2 = pl;
        end else begin
            p1 = pl;
        end
    endtask

    task automatic check_all(string tag, entry_t e);
        check_count({tag, " count_x"}, count_x, e.exp_x);
        check_count({tag, " count_y"}, count_y, e.exp_y);
        check_phase({tag, " dial_x"}, dial_x, gray_of(e.rank_x));
        check_phase({tag, " dial_y"}, dial_y, gray_of(e.rank_y));
    endtask

    // Appends one entry and its expected state after it.
    task automatic add(logic [1:0] sens, logic raw, logic rev, logic [1:0] act, logic who,
                       logic [2:0] dir, int n);
        entry_t e;
        int     moves, i;
        e     = '0;
        e.cfg = '{sensty: sens, raw: raw, reverse: rev};
        e.act = act;
        e.who = who;
        e.dir = dir;
        if (dir == D_RAND) begin
            e.dir = ($urandom % 2) ? D_INC : D_DEC;
        end
        e.n   = n[7:0];
        moves = 0;
        if (act == ACT_SPIN) begin
            moves = raw ? n : n * burst_steps(sens); // One step or one burst per toggle.
        end else if (act == ACT_LINES) begin
            for (i = 0; i < n; i++) begin
                if ((line_cnt % 8) < joy_thr(sens)) begin
                    moves++; // Joystick line.
                end
                line_cnt++;
            end
        end
        moves = moves * dir_sign(e.dir, rev);
        if (act == ACT_CLEAR) begin
            model.exp_x = '0; // Phases keep their place.
            model.exp_y = '0;
        end else if (who) begin
            model.exp_y  = model.exp_y + CW'(moves);
            model.rank_y = model.rank_y + 2'(moves);
        end else begin
            model.exp_x  = model.exp_x + CW'(moves);
            model.rank_x = model.rank_x + 2'(moves);
        end
        e.exp_x  = model.exp_x;
        e.exp_y  = model.exp_y;
        e.rank_x = model.rank_x;
        e.rank_y = model.rank_y;
        tbl.push_back(e);
    endtask

    task automatic run_entry(entry_t e, entry_t prev, int idx);
        player_in_t pl;
        entry_t     mid; // Expected state between raw steps.
        int         s, i;
        s   = dir_sign(e.dir, e.cfg.reverse);
        mid = prev;
        cfg = e.cfg;
        tick(2);
        pl = e.who ? p2 : p1;
        case (e.act)
            ACT_SPIN: begin
                for (i = 0; i < int'(e.n); i++) begin
                    pl.spinner[7] = (e.dir == D_INC);
                    pl.spinner[8] = ~pl.spinner[8];
                    drive_player(e.who, pl);
                    if (e.cfg.raw) begin
                        tick(3); // Toggle to phase, then phase to count.
                        if (e.who) begin
                            mid.exp_y  = mid.exp_y + CW'(s);
                            mid.rank_y = mid.rank_y + 2'(s);
                        end else begin
                            mid.exp_x  = mid.exp_x + CW'(s);
                            mid.rank_x = mid.rank_x + 2'(s);
                        end
                        check_all($sformatf("entry %0d step %0d", idx, i), mid);
                    end else begin
                        tick(SETTLE);
                    end
                end
            end
            ACT_LINES: begin
                pl.joystick    = '1;
                pl.joystick[0] = !(e.dir == D_INC || e.dir == D_BOTH); // Pressed is low.
                pl.joystick[1] = !(e.dir == D_DEC || e.dir == D_BOTH);
                drive_player(e.who, pl);
                for (i = 0; i < int'(e.n); i++) begin
                    lhbl = 1'b1;
                    tick(4);
                    lhbl = 1'b0;
                    tick(4);
                end
                pl.joystick = '1;
                drive_player(e.who, pl);
            end
            default: begin
                clear = 1'b1;
                tick(1);
                clear = 1'b0;
                check_count($sformatf("entry %0d cleared count_x", idx), count_x, '0);
                check_count($sformatf("entry %0d cleared count_y", idx), count_y, '0);
            end
        endcase
        tick(SETTLE);
        check_all($sformatf("entry %0d", idx), e);
    endtask

    initial begin
        int total;
        #1;
        total = 0;
        foreach (tbl[i]) total += int'(tbl[i].n);
        repeat (total * 400 + 100) @(posedge clk);
        fail_stop("Timeout: the test table did not finish in time");
    end

    initial begin
        entry_t prev;
        void'($urandom(32'h1634));
        rst      = 1'b1;
        lhbl     = 1'b0;
        clear    = 1'b0;
        cfg      = '0;
        p1       = '{joystick: '1, spinner: '0};
        p2       = '{joystick: '1, spinner: '0};
        model    = '0;
        line_cnt = 0;
        // Raw spinner, then reverse.
        add(2'd0, 1, 0, ACT_SPIN, 0, D_INC, 5);
        add(2'd0, 1, 0, ACT_SPIN, 0, D_DEC, 3);
        add(2'd1, 1, 0, ACT_SPIN, 1, D_RAND, 6);
        add(2'd0, 1, 1, ACT_SPIN, 0, D_INC, 4);
        add(2'd0, 0, 0, ACT_CLEAR, 0, D_NONE, 1);
        // Emulated spinner bursts over all sensitivities.
        add(2'd0, 0, 0, ACT_SPIN, 0, D_INC, 1);
        add(2'd1, 0, 0, ACT_SPIN, 1, D_DEC, 1);
        add(2'd2, 0, 0, ACT_SPIN, 0, D_RAND, 1);
        add(2'd3, 0, 1, ACT_SPIN, 0, D_INC, 1);
        add(2'd3, 0, 0, ACT_CLEAR, 0, D_NONE, 1);
        // Joystick cadence.
        add(2'd0, 0, 0, ACT_LINES, 0, D_INC, 8);
        add(2'd1, 0, 0, ACT_LINES, 0, D_DEC, 8);
        add(2'd2, 0, 0, ACT_LINES, 1, D_INC, 8);
        add(2'd3, 0, 0, ACT_LINES, 0, D_BOTH, 8);
        add(2'd3, 0, 0, ACT_LINES, 1, D_NONE, 8);
        add(2'd1, 0, 1, ACT_LINES, 1, D_RAND, 8);
        add(2'd3, 0, 0, ACT_LINES, 0, D_INC, 5); // Odd count spans the cadence.
        add(2'd0, 0, 0, ACT_CLEAR, 0, D_NONE, 1);
        add(2'd0, 1, 0, ACT_SPIN, 0, D_INC, 3); // Resumes from zero.
        tick(8);
        rst = 1'b0;
        tick(2);
        prev = '0; // Reset state.
        check_all("after reset", prev);
        foreach (tbl[i]) begin
            run_entry(tbl[i], prev, i);
            prev = tbl[i];
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: design/dial_top.sv
// Dial emulation plus board-side decoders; clear is a one-cycle strobe for both counters.
`timescale 1ns/1ps

module dial_top #(
    parameter int LEFT_BIT    = 0,
    parameter int COUNT_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          lhbl,
    input  dial_pkg::player_in_t          player1,
    input  dial_pkg::player_in_t          player2,
    input  dial_pkg::dial_cfg_t           cfg,
    input  logic                          clear,
    output quad_pkg::quad_t               dial_x,
    output quad_pkg::quad_t               dial_y,
    output logic signed [COUNT_WIDTH-1:0] count_x,
    output logic signed [COUNT_WIDTH-1:0] count_y
);

    dial_emu #(.LEFT_BIT(LEFT_BIT)) u_emu (
        .clk     (clk),
        .rst     (rst),
        .lhbl    (lhbl),
        .player1 (player1),
        .player2 (player2),
        .cfg     (cfg),
        .dial_x  (dial_x),
        .dial_y  (dial_y)
    );

    quad_counter #(.COUNT_WIDTH(COUNT_WIDTH)) u_count_x (
        .clk   (clk),
        .rst   (rst),
        .phase (dial_x),
        .clear (clear),
        .count (count_x)
    );

    quad_counter #(.COUNT_WIDTH(COUNT_WIDTH)) u_count_y (
        .clk   (clk),
        .rst   (rst),
        .phase (dial_y),
        .clear (clear),
        .count (count_y)
    );

endmodule

// File: design/dial_emu.sv
// Dial emulation for two players; lhbl must be a clean level and cfg must stay static.
`timescale 1ns/1ps

module dial_emu #(
    parameter int LEFT_BIT = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lhbl,
    input  dial_pkg::player_in_t player1,
    input  dial_pkg::player_in_t player2,
    input  dial_pkg::dial_cfg_t  cfg,
    output quad_pkg::quad_t      dial_x,
    output quad_pkg::quad_t      dial_y
);
    import dial_pkg::*;

    logic     lhbl_l;            // Blanking history.
    logic     line;              // Rising edge of lhbl.
    logic     cen;               // Half-rate enable for bursts.
    logic     joy_line;
    logic     last1, last2;      // Spinner bit 8 history.
    logic     toggle1, toggle2;
    cadence_t cadence;
    cadence_t threshold;
    step_t    rate1, rate2;      // Emulated steps from the rate units.
    step_t    step1, step2;      // Registered final steps.

    // Picks raw or emulated step, then applies reverse.
    function automatic step_t pick_step(step_t rate, player_in_t p, logic tog, dial_cfg_t c);
        step_t s;
        if (c.raw) begin
            s.pulse = tog; // One step per detent.
            s.inc   = p.spinner[7];
            s.dec   = ~p.spinner[7];
        end else begin
            s = rate;
        end
        if (c.reverse) begin
            {s.inc, s.dec} = {s.dec, s.inc};
        end
        return s;
    endfunction

    assign line    = lhbl & ~lhbl_l;
    assign toggle1 = last1 != player1.spinner[8];
    assign toggle2 = last2 != player2.spinner[8];

    // Joystick lines out of every eight.
    always_comb begin
        case (cfg.sensty)
            2'd1:    threshold = 3'd7;
            2'd0:    threshold = 3'd5;
            2'd3:    threshold = 3'd3;
            default: threshold = 3'd1; // Sensitivity 2.
        endcase
    end

    assign joy_line = line && (cadence < threshold);

    // Previous lhbl and spinner bit 8 levels.
    always_ff @(posedge clk) begin
        lhbl_l <= lhbl;
        last1  <= player1.spinner[8];
        last2  <= player2.spinner[8];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cadence <= '0;
            cen     <= 1'b0;
            step1   <= '0;
            step2   <= '0;
        end else begin
            cen   <= ~cen;
            step1 <= pick_step(rate1, player1, toggle1, cfg);
            step2 <= pick_step(rate2, player2, toggle2, cfg);
            if (line) begin
                cadence <= cadence + 3'd1; // Advances on each new line.
            end
        end
    end

    dial_rate #(.LEFT_BIT(LEFT_BIT)) u_rate1 (
        .clk      (clk),
        .rst      (rst),
        .player   (player1),
        .sensty   (cfg.sensty),
        .joy_line (joy_line),
        .toggle   (toggle1),
        .cen      (cen),
        .step     (rate1)
    );

    dial_rate #(.LEFT_BIT(LEFT_BIT)) u_rate2 (
        .clk      (clk),
        .rst      (rst),
        .player   (player2),
        .sensty   (cfg.sensty),
        .joy_line (joy_line),
        .toggle   (toggle2),
        .cen      (cen),
        .step     (rate2)
    );

    quad_gen u_gen_x (
        .clk   (clk),
        .rst   (rst),
        .step  (step1),
        .phase (dial_x)
    );

    quad_gen u_gen_y (
        .clk   (clk),
        .rst   (rst),
        .step  (step2),
        .phase (dial_y)
    );

endmodule

// File: design/quad_counter.sv
// Quadrature decoder; a two-place jump is ambiguous and is dropped, and the count wraps.
`timescale 1ns/1ps

module quad_counter #(
    parameter int COUNT_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  quad_pkg::quad_t               phase,
    input  logic                          clear,
    output logic signed [COUNT_WIDTH-1:0] count
);
    import quad_pkg::*;

    localparam logic signed [COUNT_WIDTH-1:0] ONE = 1;

    quad_t      phase_l; // Phase seen last cycle.
    logic [1:0] delta;   // Gray-order distance, modulo four.

    assign delta = quad_rank(phase) - quad_rank(phase_l);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_l <= QUAD_P0;
            count   <= '0;
        end else begin
            phase_l <= phase;
            if (clear) begin
                count <= '0; // Clear beats a move in the same cycle.
            end else begin
                case (delta)
                    2'd1:    count <= count + ONE; // One place forward.
                    2'd3:    count <= count - ONE; // One place back.
                    default: count <= count;       // Still, or a jump of two.
                endcase
            end
        end
    end

endmodule

// File: design/quad_gen.sv
// Phase generator; a step with both or neither direction set leaves the phase alone.
`timescale 1ns/1ps

module quad_gen (
    input  logic            clk,
    input  logic            rst,
    input  dial_pkg::step_t step,
    output quad_pkg::quad_t phase
);
    import quad_pkg::*;

    logic fwd;  // Forward move requested.
    logic back; // Backward move requested.

    assign fwd  = step.pulse && step.inc && !step.dec;
    assign back = step.pulse && step.dec && !step.inc;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= QUAD_P0; // Both lines low.
        end else if (fwd) begin
            phase <= quad_next(phase); // One place up the gray order.
        end else if (back) begin
            phase <= quad_prev(phase); // One place down.
        end
    end

endmodule

// File: design/dial_rate.sv
// Step source for one player; bursts fit 8 signed bits only for the 2-bit sensitivity range.
`timescale 1ns/1ps

module dial_rate #(
    parameter int LEFT_BIT = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dial_pkg::player_in_t player,
    input  logic [1:0]           sensty,
    input  logic                 joy_line,
    input  logic                 toggle,
    input  logic                 cen,
    output dial_pkg::step_t      step
);
    import dial_pkg::*;

    logic signed [7:0] burst;     // Pending steps, sign gives direction.
    logic        [7:0] burst_len; // Length loaded on a toggle.
    logic              burst_go;  // A burst step fires this cycle.
    step_t             next_step;

    // 8 << sensty plus 2 gives 10, 18, 34 or 66 steps.
    assign burst_len = (8'd8 << sensty) + 8'd2;

    assign burst_go = !joy_line && cen && (burst != 8'sd0);

    always_comb begin
        next_step = '0;
        if (joy_line) begin
            next_step.pulse = 1'b1; // Joystick line wins the cycle.
            next_step.inc   = ~player.joystick[LEFT_BIT];
            next_step.dec   = ~player.joystick[LEFT_BIT+1];
        end else if (burst_go) begin
            next_step.pulse = 1'b1;
            next_step.inc   = (burst > 8'sd0);
            next_step.dec   = (burst < 8'sd0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            burst <= 8'sd0;
            step  <= '0;
        end else begin
            step <= next_step; // Registered step.
            if (toggle) begin
                // A new detent restarts the burst.
                burst <= player.spinner[7] ? $signed(burst_len) : -$signed(burst_len);
            end else if (burst_go) begin
                burst <= (burst > 8'sd0) ? burst - 8'sd1 : burst + 8'sd1; // Count to zero.
            end
        end
    end

endmodule

// File: design/quad_pkg.sv
// Quadrature phase type and gray-order helpers; all phase math wraps modulo four.
package quad_pkg;

    typedef logic [1:0] quad_t;

    // The four phases in increasing gray order.
    localparam quad_t QUAD_P0 = 2'b00;
    localparam quad_t QUAD_P1 = 2'b01;
    localparam quad_t QUAD_P2 = 2'b11;
    localparam quad_t QUAD_P3 = 2'b10;

    // Position of a phase in the gray order.
    function automatic logic [1:0] quad_rank(quad_t q);
        case (q)
            QUAD_P1: return 2'd1;
            QUAD_P2: return 2'd2;
            QUAD_P3: return 2'd3;
            default: return 2'd0; // QUAD_P0.
        endcase
    endfunction

    // Phase that sits at a given place in the order.
    function automatic quad_t quad_from_rank(logic [1:0] r);
        case (r)
            2'd1:    return QUAD_P1;
            2'd2:    return QUAD_P2;
            2'd3:    return QUAD_P3;
            default: return QUAD_P0;
        endcase
    endfunction

    function automatic quad_t quad_next(quad_t q);
        return quad_from_rank(quad_rank(q) + 2'd1); // Wraps 10 back to 00.
    endfunction

    function automatic quad_t quad_prev(quad_t q);
        return quad_from_rank(quad_rank(q) - 2'd1); // Wraps 00 back to 10.
    endfunction

endpackage

// File: design/dial_pkg.sv
// Player-side types; joystick bits are active low and spinner bit 8 toggles once per detent.
package dial_pkg;

    // One player's raw controls, 19 bits in all.
    typedef struct packed {
        logic [9:0] joystick; // Active-low buttons and directions.
        logic [8:0] spinner;  // Bit 8 toggles per detent, bit 7 is direction.
    } player_in_t;

    // Static configuration, 4 bits in all.
    typedef struct packed {
        logic [1:0] sensty;  // Burst length and joystick cadence select.
        logic       raw;     // Spinner toggles map one to one onto steps.
        logic       reverse; // Flips direction in every mode.
    } dial_cfg_t;

    // One step command towards a phase generator.
    typedef struct packed {
        logic pulse; // Step strobe.
        logic inc;   // Move forward.
        logic dec;   // Move back.
    } step_t;

    // Line counter that sets the joystick cadence.
    typedef logic [2:0] cadence_t;

endpackage
